//--- verilog/pipe16_pkg.sv
package pipe16_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  addr_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [15:0] instr_t;

    localparam int REG_COUNT = 8;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////
    localparam opcode_t OP_NOP   = 5'b00000;
    localparam opcode_t OP_HALT  = 5'b00001;
    localparam opcode_t OP_LOAD  = 5'b00010;
    localparam opcode_t OP_STORE = 5'b00011;
    localparam opcode_t OP_LDIH  = 5'b10000;
    localparam opcode_t OP_ADD   = 5'b01000;
    localparam opcode_t OP_ADDI  = 5'b01001;
    localparam opcode_t OP_ADDC  = 5'b10001;
    localparam opcode_t OP_SUB   = 5'b01010;
    localparam opcode_t OP_SUBI  = 5'b01011;
    localparam opcode_t OP_SUBC  = 5'b10010;
    localparam opcode_t OP_CMP   = 5'b01100;
    localparam opcode_t OP_AND   = 5'b01101;
    localparam opcode_t OP_OR    = 5'b01110;
    localparam opcode_t OP_XOR   = 5'b01111;
    localparam opcode_t OP_SLL   = 5'b00100;
    localparam opcode_t OP_SRL   = 5'b00110;
    localparam opcode_t OP_SLA   = 5'b00101;
    localparam opcode_t OP_SRA   = 5'b00111;
    localparam opcode_t OP_JUMP  = 5'b11000;
    localparam opcode_t OP_JMPR  = 5'b11001;
    localparam opcode_t OP_BZ    = 5'b11010;
    localparam opcode_t OP_BNZ   = 5'b11011;
    localparam opcode_t OP_BN    = 5'b11100;
    localparam opcode_t OP_BNN   = 5'b11101;
    localparam opcode_t OP_BC    = 5'b11110;
    localparam opcode_t OP_BNC   = 5'b11111;
    localparam opcode_t OP_NOR   = 5'b10101;
    localparam opcode_t OP_NXOR  = 5'b10110;
    localparam opcode_t OP_NAND  = 5'b10111;

    localparam instr_t INSTR_NOP = {OP_NOP, 11'b0};

    typedef enum logic {RUN_IDLE, RUN_EXEC} run_state_e;

    // One stage's outcome, seen by forwarding and writeback
    typedef struct packed {
        logic     writes;
        reg_idx_t dest;
        word_t    value;
        instr_t   instr;
    } stage_result_t;

    // r1 with 8-bit immediate
    function automatic logic is_reg_imm(opcode_t op);
        return op inside {OP_LDIH, OP_ADDI, OP_SUBI, OP_JUMP, OP_JMPR,
                          OP_BZ, OP_BNZ, OP_BN, OP_BNN, OP_BC, OP_BNC};
    endfunction

    // r1, r2 with 4-bit immediate
    function automatic logic is_two_reg(opcode_t op);
        return op inside {OP_LOAD, OP_STORE, OP_SLL, OP_SRL, OP_SLA, OP_SRA};
    endfunction

    function automatic logic writes_reg(opcode_t op);
        return op inside {OP_LOAD, OP_LDIH, OP_ADD, OP_ADDI, OP_ADDC, OP_SUB,
                          OP_SUBI, OP_SUBC, OP_AND, OP_OR, OP_XOR, OP_SLL,
                          OP_SRL, OP_SLA, OP_SRA, OP_NOR, OP_NAND, OP_NXOR};
    endfunction

    // Any source field of the format counts as a read
    function automatic logic reads_reg(instr_t ins, reg_idx_t idx);
        opcode_t op;
        op = ins[15:11];
        if (is_reg_imm(op))
            return ins[10:8] == idx;
        if (is_two_reg(op))
            return ins[6:4] == idx || (op == OP_STORE && ins[10:8] == idx);
        return ins[6:4] == idx || ins[2:0] == idx;
    endfunction

endpackage

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  pipe16_pkg::opcode_t i_op,
    input  pipe16_pkg::word_t   i_a,
    input  pipe16_pkg::word_t   i_b,
    input  logic                i_carry,
    output pipe16_pkg::word_t   o_result,
    output logic                o_carry
);
    import pipe16_pkg::*;

    logic [16:0] wide;
    logic [3:0]  shamt;

    assign shamt = i_b[3:0];

    always_comb
    begin
        wide = '0;
        case (i_op)
            // Address and target sums
            OP_LOAD, OP_STORE, OP_JMPR,
            OP_BZ, OP_BNZ, OP_BN, OP_BNN, OP_BC, OP_BNC:
                wide[15:0] = i_a + i_b;
            OP_LDIH:
                wide[15:0] = i_a + {i_b[7:0], 8'b0};
            OP_ADD, OP_ADDI:
                wide = {1'b0, i_a} + {1'b0, i_b};
            OP_ADDC:
                wide = {1'b0, i_a} + {1'b0, i_b} + i_carry;
            // Borrow lands in bit 16
            OP_SUB, OP_SUBI, OP_CMP:
                wide = {1'b0, i_a} - {1'b0, i_b};
            OP_SUBC:
                wide = {1'b0, i_a} - {1'b0, i_b} - i_carry;
            OP_AND:  wide[15:0] = i_a & i_b;
            OP_OR:   wide[15:0] = i_a | i_b;
            OP_XOR:  wide[15:0] = i_a ^ i_b;
            OP_NAND: wide[15:0] = ~(i_a & i_b);
            OP_NOR:  wide[15:0] = ~(i_a | i_b);
            OP_NXOR: wide[15:0] = ~(i_a ^ i_b);
            OP_SLL, OP_SLA:
                wide[15:0] = i_a << shamt;
            OP_SRL:
                wide[15:0] = i_a >> shamt;
            OP_SRA:
                wide[15:0] = $signed(i_a) >>> shamt;
            OP_JUMP:
                wide[15:0] = i_b;
            default:
                wide = '0;
        endcase
    end

    assign o_result = wide[15:0];
    assign o_carry  = wide[16];

endmodule

//--- verilog/run_control.sv
`timescale 1ns/1ps

module run_control (
    input  logic clock,
    input  logic reset,
    input  logic i_enable,
    input  logic i_start,
    input  logic i_halt_seen,
    output logic o_running
);
    import pipe16_pkg::*;

    run_state_e state_q, state_next;

    always_comb
    begin
        state_next = state_q;
        case (state_q)
            RUN_IDLE:
                if (i_enable && i_start)
                    state_next = RUN_EXEC;
            RUN_EXEC:
                if (!i_enable || i_halt_seen)
                    state_next = RUN_IDLE;
            default:
                state_next = RUN_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
            state_q <= RUN_IDLE;
        else
            state_q <= state_next;
    end

    assign o_running = (state_q == RUN_EXEC);

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic               clock,
    input  logic               reset,
    input  logic               i_running,
    input  pipe16_pkg::instr_t i_instr,
    output pipe16_pkg::addr_t  o_instr_addr,
    input  pipe16_pkg::instr_t i_decode_instr,
    input  logic               i_branch_taken,
    input  pipe16_pkg::addr_t  i_branch_target,
    output pipe16_pkg::instr_t o_fetched
);
    import pipe16_pkg::*;

    addr_t  pc_q;
    instr_t fetched_q;
    logic   load_use;

    // Result of a LOAD in decode is not ready for the next instruction
    assign load_use = (i_decode_instr[15:11] == OP_LOAD)
                   && reads_reg(i_instr, i_decode_instr[10:8]);

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            pc_q      <= '0;
            fetched_q <= INSTR_NOP;
        end
        else if (i_running)
        begin
            if (i_branch_taken)
            begin
                pc_q      <= i_branch_target;
                fetched_q <= INSTR_NOP;
            end
            else if (load_use)
                fetched_q <= INSTR_NOP;
            else
            begin
                pc_q      <= pc_q + 1'b1;
                fetched_q <= i_instr;
            end
        end
    end

    assign o_instr_addr = pc_q;
    assign o_fetched    = fetched_q;

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      i_running,
    input  pipe16_pkg::instr_t        i_fetched,
    input  pipe16_pkg::stage_result_t i_exec_result,
    input  pipe16_pkg::stage_result_t i_mem_result,
    input  pipe16_pkg::stage_result_t i_wb_result,
    output pipe16_pkg::reg_idx_t      o_read_a,
    output pipe16_pkg::reg_idx_t      o_read_b,
    input  pipe16_pkg::word_t         i_reg_a,
    input  pipe16_pkg::word_t         i_reg_b,
    input  logic                      i_branch_taken,
    output pipe16_pkg::instr_t        o_instr,
    output pipe16_pkg::word_t         o_operand_a,
    output pipe16_pkg::word_t         o_operand_b,
    output pipe16_pkg::word_t         o_store_data
);
    import pipe16_pkg::*;

    opcode_t op;
    logic    reg_imm, two_reg, is_store;
    word_t   fwd_a, fwd_b;
    word_t   operand_b_next;

    instr_t  instr_q;
    word_t   operand_a_q, operand_b_q, store_q;

    // Youngest writer wins
    function automatic word_t forward(reg_idx_t idx, word_t reg_value);
        if (i_exec_result.writes && i_exec_result.dest == idx)
            return i_exec_result.value;
        if (i_mem_result.writes && i_mem_result.dest == idx)
            return i_mem_result.value;
        if (i_wb_result.writes && i_wb_result.dest == idx)
            return i_wb_result.value;
        return reg_value;
    endfunction

    assign op       = i_fetched[15:11];
    assign reg_imm  = is_reg_imm(op);
    assign two_reg  = is_two_reg(op);
    assign is_store = (op == OP_STORE);

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////
    assign o_read_a = reg_imm  ? i_fetched[10:8] : i_fetched[6:4];
    assign o_read_b = is_store ? i_fetched[10:8] : i_fetched[2:0];

    always_comb
    begin
        fwd_a = forward(o_read_a, i_reg_a);
        fwd_b = forward(o_read_b, i_reg_b);
    end

    always_comb
    begin
        if (reg_imm)
            operand_b_next = {8'b0, i_fetched[7:0]};
        else if (two_reg)
            operand_b_next = {12'b0, i_fetched[3:0]};
        else
            operand_b_next = fwd_b;
    end

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
            instr_q <= INSTR_NOP;
        else if (i_running)
            instr_q <= i_branch_taken ? INSTR_NOP : i_fetched;
    end

    always_ff @(posedge clock)
    begin
        if (i_running)
        begin
            operand_a_q <= fwd_a;
            operand_b_q <= operand_b_next;
            store_q     <= is_store ? fwd_b : '0;
        end
    end

    assign o_instr      = instr_q;
    assign o_operand_a  = operand_a_q;
    assign o_operand_b  = operand_b_q;
    assign o_store_data = store_q;

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      i_running,
    input  pipe16_pkg::instr_t        i_instr,
    input  pipe16_pkg::word_t         i_operand_a,
    input  pipe16_pkg::word_t         i_operand_b,
    input  pipe16_pkg::word_t         i_store_data,
    input  pipe16_pkg::word_t         i_data_rdata,
    output pipe16_pkg::stage_result_t o_exec_result,
    output pipe16_pkg::stage_result_t o_mem_result,
    output pipe16_pkg::addr_t         o_data_addr,
    output pipe16_pkg::word_t         o_data_wdata,
    output logic                      o_data_we,
    output logic                      o_branch_taken,
    output pipe16_pkg::addr_t         o_branch_target
);
    import pipe16_pkg::*;

    opcode_t ex_op, mem_op;
    word_t   alu_result;
    logic    alu_carry;
    logic    sets_c, sets_zn;

    instr_t  mem_instr_q;
    word_t   alu_q, store_q;
    logic    we_q, zf_q, nf_q, cf_q;

    assign ex_op  = i_instr[15:11];
    assign mem_op = mem_instr_q[15:11];

    alu alu0 (
        .i_op     (ex_op),
        .i_a      (i_operand_a),
        .i_b      (i_operand_b),
        .i_carry  (cf_q),
        .o_result (alu_result),
        .o_carry  (alu_carry)
    );

    assign sets_c  = ex_op inside {OP_ADD, OP_ADDI, OP_ADDC, OP_SUB, OP_SUBI, OP_SUBC, OP_CMP};
    assign sets_zn = sets_c || (ex_op == OP_LDIH);

    ////////////////////////////////////////////////////////////
    // Branch decision, memory stage
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        case (mem_op)
            OP_BZ:   o_branch_taken = zf_q;
            OP_BNZ:  o_branch_taken = !zf_q;
            OP_BN:   o_branch_taken = nf_q;
            OP_BNN:  o_branch_taken = !nf_q;
            OP_BC:   o_branch_taken = cf_q;
            OP_BNC:  o_branch_taken = !cf_q;
            OP_JUMP: o_branch_taken = 1'b1;
            OP_JMPR: o_branch_taken = 1'b1;
            default: o_branch_taken = 1'b0;
        endcase
    end

    // Instruction in execute is squashed by a taken branch
    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            mem_instr_q <= INSTR_NOP;
            we_q        <= 1'b0;
            zf_q        <= 1'b0;
            nf_q        <= 1'b0;
            cf_q        <= 1'b0;
        end
        else if (i_running)
        begin
            mem_instr_q <= o_branch_taken ? INSTR_NOP : i_instr;
            we_q        <= (ex_op == OP_STORE) && !o_branch_taken;
            if (sets_zn && !o_branch_taken)
            begin
                zf_q <= (alu_result == '0);
                nf_q <= alu_result[15];
            end
            if (sets_c && !o_branch_taken)
                cf_q <= alu_carry;
        end
    end

    always_ff @(posedge clock)
    begin
        if (i_running)
        begin
            alu_q   <= alu_result;
            store_q <= i_store_data;
        end
    end

    assign o_exec_result = '{writes: writes_reg(ex_op), dest: i_instr[10:8],
                             value: alu_result, instr: i_instr};
    assign o_mem_result  = '{writes: writes_reg(mem_op), dest: mem_instr_q[10:8],
                             value: (mem_op == OP_LOAD) ? i_data_rdata : alu_q,
                             instr: mem_instr_q};

    assign o_data_addr     = alu_q[7:0];
    assign o_data_wdata    = store_q;
    assign o_data_we       = we_q && i_running;
    assign o_branch_target = alu_q[7:0];

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      i_running,
    input  pipe16_pkg::stage_result_t i_mem_result,
    input  pipe16_pkg::reg_idx_t      i_read_a,
    input  pipe16_pkg::reg_idx_t      i_read_b,
    output pipe16_pkg::word_t         o_reg_a,
    output pipe16_pkg::word_t         o_reg_b,
    output pipe16_pkg::stage_result_t o_wb_result,
    output logic                      o_halt_seen,
    input  pipe16_pkg::reg_idx_t      i_debug_sel,
    output pipe16_pkg::word_t         o_debug_data
);
    import pipe16_pkg::*;

    stage_result_t wb_q;
    word_t         regs [REG_COUNT];

    // Registers are written one edge after the writeback register
    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            wb_q <= '0;
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (i_running)
        begin
            wb_q <= i_mem_result;
            if (wb_q.writes)
                regs[wb_q.dest] <= wb_q.value;
        end
    end

    assign o_reg_a      = regs[i_read_a];
    assign o_reg_b      = regs[i_read_b];
    assign o_debug_data = regs[i_debug_sel];
    assign o_wb_result  = wb_q;
    assign o_halt_seen  = (wb_q.instr[15:11] == OP_HALT);

endmodule

//--- verilog/pipe16_top.sv
`timescale 1ns/1ps

module pipe16_top (
    input  logic               clock,
    input  logic               reset,
    input  logic               i_enable,
    input  logic               i_start,
    output pipe16_pkg::addr_t  o_instr_addr,
    input  pipe16_pkg::instr_t i_instr,
    output pipe16_pkg::addr_t  o_data_addr,
    output pipe16_pkg::word_t  o_data_wdata,
    output logic               o_data_we,
    input  pipe16_pkg::word_t  i_data_rdata,
    input  pipe16_pkg::reg_idx_t i_debug_sel,
    output pipe16_pkg::word_t  o_debug_data,
    output logic               o_running
);
    import pipe16_pkg::*;

    logic          halt_seen;
    logic          branch_taken;
    addr_t         branch_target;
    instr_t        fetched;
    instr_t        exec_instr;
    word_t         operand_a, operand_b, store_data;
    stage_result_t exec_result, mem_result, wb_result;
    reg_idx_t      read_a, read_b;
    word_t         reg_a, reg_b;

    run_control run_control0 (
        .clock       (clock),
        .reset       (reset),
        .i_enable    (i_enable),
        .i_start     (i_start),
        .i_halt_seen (halt_seen),
        .o_running   (o_running)
    );

    // Fetch register doubles as the decode-stage instruction
    fetch_stage fetch0 (
        .clock           (clock),
        .reset           (reset),
        .i_running       (o_running),
        .i_instr         (i_instr),
        .o_instr_addr    (o_instr_addr),
        .i_decode_instr  (fetched),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_fetched       (fetched)
    );

    decode_stage decode0 (
        .clock          (clock),
        .reset          (reset),
        .i_running      (o_running),
        .i_fetched      (fetched),
        .i_exec_result  (exec_result),
        .i_mem_result   (mem_result),
        .i_wb_result    (wb_result),
        .o_read_a       (read_a),
        .o_read_b       (read_b),
        .i_reg_a        (reg_a),
        .i_reg_b        (reg_b),
        .i_branch_taken (branch_taken),
        .o_instr        (exec_instr),
        .o_operand_a    (operand_a),
        .o_operand_b    (operand_b),
        .o_store_data   (store_data)
    );

    execute_stage execute0 (
        .clock           (clock),
        .reset           (reset),
        .i_running       (o_running),
        .i_instr         (exec_instr),
        .i_operand_a     (operand_a),
        .i_operand_b     (operand_b),
        .i_store_data    (store_data),
        .i_data_rdata    (i_data_rdata),
        .o_exec_result   (exec_result),
        .o_mem_result    (mem_result),
        .o_data_addr     (o_data_addr),
        .o_data_wdata    (o_data_wdata),
        .o_data_we       (o_data_we),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target)
    );

    register_file register_file0 (
        .clock        (clock),
        .reset        (reset),
        .i_running    (o_running),
        .i_mem_result (mem_result),
        .i_read_a     (read_a),
        .i_read_b     (read_b),
        .o_reg_a      (reg_a),
        .o_reg_b      (reg_b),
        .o_wb_result  (wb_result),
        .o_halt_seen  (halt_seen),
        .i_debug_sel  (i_debug_sel),
        .o_debug_data (o_debug_data)
    );

endmodule

//--- testbench/pipe16_props.sv
`timescale 1ns/1ps

module pipe16_props (
    input logic                clock,
    input logic                reset,
    input logic                i_start,
    input logic                i_data_we,
    input logic                i_running,
    input pipe16_pkg::opcode_t i_mem_op,
    input pipe16_pkg::addr_t   i_instr_addr
);
    import pipe16_pkg::*;

    int assert_failures = 0;

    // Store strobe only for a STORE in the memory stage of a running pipeline
    no_store_when_idle: assert property (@(posedge clock) disable iff (!reset)
        i_data_we |-> i_running && (i_mem_op == OP_STORE))
    else
    begin
        assert_failures++;
        $error("o_data_we high while not running or without a STORE in memory");
    end

    // Idle out of reset until start
    idle_until_start: assert property (@(posedge clock) disable iff (!reset)
        !i_running && !i_start |=> !i_running)
    else
    begin
        assert_failures++;
        $error("o_running rose without start");
    end

    // Program counter frozen while idle
    pc_holds_when_idle: assert property (@(posedge clock) disable iff (!reset)
        !i_running |=> $stable(i_instr_addr))
    else
    begin
        assert_failures++;
        $error("o_instr_addr moved while not running");
    end

endmodule

//--- testbench/pipe16_tb.sv
`timescale 1ns/1ps

module pipe16_tb;
    import pipe16_pkg::*;

    localparam int  FIXED_ROWS  = 15;
    localparam int  ROW_COUNT   = 24;
    localparam int  RUN_LIMIT   = 40;
    localparam time WATCHDOG_NS = ROW_COUNT * 60 * 40;

    typedef struct packed {
        opcode_t op;
        word_t   a;
        word_t   b;
        word_t   want;
    } row_t;

    logic     clock;
    logic     reset;
    logic     enable;
    logic     start;
    reg_idx_t debug_sel;
    addr_t    instr_addr;
    instr_t   instr;
    addr_t    data_addr;
    word_t    data_wdata;
    logic     data_we;
    word_t    data_rdata;
    word_t    debug_data;
    logic     running;

    instr_t      imem [256];
    word_t       dmem [256];
    row_t        rows [ROW_COUNT];
    word_t       regs_seen [REG_COUNT];
    opcode_t     op_list [FIXED_ROWS];
    logic [31:0] rng_state;
    int          errors;
    int          failed_tests;
    int          errors_before;
    int          assert_errors;
    int          we_count = 0;
    addr_t       we_addr;
    word_t       we_data;

    pipe16_top dut0 (
        .clock        (clock),
        .reset        (reset),
        .i_enable     (enable),
        .i_start      (start),
        .o_instr_addr (instr_addr),
        .i_instr      (instr),
        .o_data_addr  (data_addr),
        .o_data_wdata (data_wdata),
        .o_data_we    (data_we),
        .i_data_rdata (data_rdata),
        .i_debug_sel  (debug_sel),
        .o_debug_data (debug_data),
        .o_running    (running)
    );

    bind pipe16_top pipe16_props props0 (
        .clock        (clock),
        .reset        (reset),
        .i_start      (i_start),
        .i_data_we    (o_data_we),
        .i_running    (o_running),
        .i_mem_op     (mem_result.instr[15:11]),
        .i_instr_addr (o_instr_addr)
    );

    always #20 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////
    assign instr      = imem[instr_addr];
    assign data_rdata = dmem[data_addr];

    // Fill under reset, so a missed store is visible at address 8
    always @(posedge clock)
    begin
        if (!reset)
        begin
            for (int i = 0; i < 256; i++)
                dmem[i] <= {i[7:0], ~i[7:0]};
        end
        else if (data_we)
        begin
            dmem[data_addr] <= data_wdata;
            we_count = we_count + 1;
            we_addr  = data_addr;
            we_data  = data_wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference rules and helpers
    ////////////////////////////////////////////////////////////
    function automatic word_t rule_result(opcode_t op, word_t a, word_t b);
        case (op)
            OP_ADD, OP_ADDC: return a + b;
            OP_SUB, OP_SUBC: return a - b;
            OP_AND:          return a & b;
            OP_OR:           return a | b;
            OP_XOR:          return a ^ b;
            OP_NAND:         return ~(a & b);
            OP_NOR:          return ~(a | b);
            OP_NXOR:         return ~(a ^ b);
            OP_SLL, OP_SLA:  return a << b[3:0];
            OP_SRL:          return a >> b[3:0];
            OP_SRA:          return $signed(a) >>> b[3:0];
            // CMP leaves r3 untouched
            default:         return '0;
        endcase
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic instr_t encode_imm(opcode_t op, reg_idx_t rd, logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    function automatic instr_t encode_reg(opcode_t op, reg_idx_t rd, reg_idx_t ra,
                                          logic [3:0] low);
        return {op, rd, 1'b0, ra, low};
    endfunction

    task automatic check_value(input string what, input word_t got, input word_t want);
        if (got !== want)
        begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic build_table();
        opcode_t op;
        word_t   a;
        word_t   b;
        rows[0]  = '{OP_ADD,  16'h1234, 16'h4321, 16'h5555};
        rows[1]  = '{OP_ADDC, 16'hffff, 16'h0001, 16'h0000};
        rows[2]  = '{OP_SUB,  16'h5000, 16'h1234, 16'h3dcc};
        rows[3]  = '{OP_SUBC, 16'h0010, 16'h0020, 16'hfff0};
        rows[4]  = '{OP_CMP,  16'h00aa, 16'h00aa, 16'h0000};
        rows[5]  = '{OP_AND,  16'hf0f0, 16'h0f0f, 16'h0000};
        rows[6]  = '{OP_OR,   16'hf000, 16'h000f, 16'hf00f};
        rows[7]  = '{OP_XOR,  16'haaaa, 16'h5555, 16'hffff};
        rows[8]  = '{OP_NAND, 16'hffff, 16'h00ff, 16'hff00};
        rows[9]  = '{OP_NOR,  16'h1200, 16'h0034, 16'hedcb};
        rows[10] = '{OP_NXOR, 16'h1234, 16'h1234, 16'hffff};
        rows[11] = '{OP_SLL,  16'h0001, 16'h0004, 16'h0010};
        rows[12] = '{OP_SLA,  16'h8001, 16'h0001, 16'h0002};
        rows[13] = '{OP_SRL,  16'h8000, 16'h000f, 16'h0001};
        rows[14] = '{OP_SRA,  16'h8000, 16'h0003, 16'hf000};
        for (int i = 0; i < FIXED_ROWS; i++)
            op_list[i] = rows[i].op;
        rng_state = 32'hd666_3f0a;
        for (int i = FIXED_ROWS; i < ROW_COUNT; i++)
        begin
            rng_state = xorshift(rng_state);
            a         = rng_state[15:0];
            op        = op_list[rng_state[31:16] % FIXED_ROWS];
            rng_state = xorshift(rng_state);
            b         = rng_state[15:0];
            // Every third row gives a zero result
            if (i % 3 == 0)
            begin
                op = (i % 2 == 0) ? OP_XOR : OP_SUB;
                b  = a;
            end
            rows[i] = '{op, a, b, rule_result(op, a, b)};
        end
    endtask

    task automatic load_program(input row_t row);
        instr_t op_instr;
        for (int i = 0; i < 256; i++)
            imem[i] = '0;
        if (row.op inside {OP_SLL, OP_SLA, OP_SRL, OP_SRA})
            op_instr = encode_reg(row.op, 3'd3, 3'd1, row.b[3:0]);
        else
            op_instr = encode_reg(row.op, 3'd3, 3'd1, 4'd2);
        imem[0]  = encode_imm(OP_LDIH, 3'd1, row.a[15:8]);
        imem[1]  = encode_imm(OP_ADDI, 3'd1, row.a[7:0]);
        imem[2]  = encode_imm(OP_LDIH, 3'd2, row.b[15:8]);
        imem[3]  = encode_imm(OP_ADDI, 3'd2, row.b[7:0]);
        imem[4]  = op_instr;
        imem[5]  = encode_reg(OP_STORE, 3'd3, 3'd0, 4'd8);
        imem[6]  = encode_reg(OP_LOAD, 3'd4, 3'd0, 4'd8);
        imem[7]  = encode_reg(OP_ADD, 3'd5, 3'd4, 4'd0);
        imem[8]  = encode_imm(OP_BZ, 3'd0, 8'd11);
        imem[9]  = encode_imm(OP_ADDI, 3'd6, 8'd1);
        imem[10] = encode_imm(OP_ADDI, 3'd6, 8'd2);
        imem[11] = encode_imm(OP_HALT, 3'd0, 8'd0);
        // Younger than HALT, never reaches the registers
        imem[12] = encode_imm(OP_ADDI, 3'd7, 8'd1);
    endtask

    task automatic run_row(input row_t row);
        int cycles;
        int we_before;
        load_program(row);
        @(posedge clock);
        reset  <= 1'b0;
        enable <= 1'b0;
        start  <= 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        check_value("o_running after reset", {15'b0, running}, 16'h0000);
        @(posedge clock);
        enable <= 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        check_value("o_running before start", {15'b0, running}, 16'h0000);
        @(posedge clock);
        start <= 1'b1;
        we_before = we_count;
        @(posedge clock);
        start <= 1'b0;
        @(negedge clock);
        if (!running)
        begin
            $display("o_running did not rise after start at %0t", $time);
            errors++;
        end
        cycles = 0;
        while (running && cycles < RUN_LIMIT)
        begin
            @(negedge clock);
            cycles++;
        end
        if (running)
        begin
            $display("Program did not halt within %0d cycles", RUN_LIMIT);
            errors++;
        end
        @(posedge clock);
        enable <= 1'b0;
        for (int r = 0; r < REG_COUNT; r++)
        begin
            @(posedge clock);
            debug_sel <= reg_idx_t'(r);
            @(negedge clock);
            regs_seen[r] = debug_data;
        end
        check_value("r0", regs_seen[0], 16'h0000);
        check_value("r1", regs_seen[1], row.a);
        check_value("r2", regs_seen[2], row.b);
        check_value("r3", regs_seen[3], row.want);
        check_value("store count", 16'(we_count - we_before), 16'd1);
        check_value("store address", {8'b0, we_addr}, 16'h0008);
        check_value("store data", we_data, row.want);
        check_value("memory word 8", dmem[8], row.want);
        check_value("r4", regs_seen[4], row.want);
        check_value("r5", regs_seen[5], row.want);
        check_value("r6", regs_seen[6], (row.want == '0) ? 16'd0 : 16'd3);
        check_value("r7", regs_seen[7], 16'h0000);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        clock        = 1'b0;
        reset        = 1'b0;
        enable       = 1'b0;
        start        = 1'b0;
        debug_sel    = '0;
        errors       = 0;
        failed_tests = 0;
        build_table();
        for (int i = 0; i < ROW_COUNT; i++)
        begin
            errors_before = errors;
            run_row(rows[i]);
            if (errors == errors_before)
                $display("Test %0d op %b a %h b %h: pass", i, rows[i].op, rows[i].a, rows[i].b);
            else
            begin
                failed_tests++;
                $display("Test %0d op %b a %h b %h: FAIL", i, rows[i].op, rows[i].a, rows[i].b);
            end
        end
        assert_errors = dut0.props0.assert_failures;
        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 ROW_COUNT, failed_tests, errors, assert_errors);
        if (errors == 0 && assert_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Run timed out at %0t before all tests finished", $time);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- pipe16.f
verilog/pipe16_pkg.sv
verilog/alu.sv
verilog/run_control.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/register_file.sv
verilog/pipe16_top.sv
testbench/pipe16_props.sv
testbench/pipe16_tb.sv

//--- Bender.yml
package:
  name: pipe16

sources:
  - verilog/pipe16_pkg.sv
  - verilog/alu.sv
  - verilog/run_control.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/register_file.sv
  - verilog/pipe16_top.sv
  - target: test
    files:
      - testbench/pipe16_props.sv
      - testbench/pipe16_tb.sv
